// File: dv/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// program words, word address = table index
localparam int prog_len = 30;
localparam logic [31:0] prog_words [prog_len] = '{
	// dependent alu chain, ex, mem and wb bypass
	{`OP_ORI,  5'd1,  5'd0,  16'h8001},
	{`OP_ADDI, 5'd2,  5'd0,  16'hfff0},
	{`OP_ALU,  5'd3,  5'd1,  5'd2,  6'd0, `SUB_ADD},
	{`OP_ALU,  5'd4,  5'd3,  5'd1,  6'd0, `SUB_SUB},
	{`OP_ALU,  5'd5,  5'd4,  5'd3,  6'd0, `SUB_XOR},
	{`OP_ALU,  5'd6,  5'd5,  5'd1,  6'd0, `SUB_AND},
	{`OP_ALU,  5'd7,  5'd6,  5'd4,  6'd0, `SUB_OR},
	{`OP_SW,   5'd7,  5'd0,  16'h0100},
	{`OP_SW,   5'd6,  5'd0,  16'h0104},
	{`OP_SW,   5'd5,  5'd0,  16'h0108},
	{`OP_SW,   5'd4,  5'd0,  16'h010c},
	{`OP_SW,   5'd3,  5'd0,  16'h0110},
	{`OP_SW,   5'd1,  5'd0,  16'h0114},
	{`OP_SW,   5'd2,  5'd0,  16'h0118},
	// store then reload, load-use on the add
	{`OP_ADDI, 5'd8,  5'd0,  16'h0200},
	{`OP_SW,   5'd5,  5'd8,  16'h0004},
	{`OP_LW,   5'd9,  5'd8,  16'h0004},
	{`OP_ALU,  5'd10, 5'd9,  5'd1,  6'd0, `SUB_ADD},
	{`OP_SW,   5'd10, 5'd8,  16'h0008},
	// untaken beq, taken beq, j, each shadow slot holds a store
	{`OP_BEQ,  5'd10, 5'd0,  16'h0003},
	{`OP_SW,   5'd1,  5'd8,  16'h000c},
	{`OP_BEQ,  5'd4,  5'd2,  16'h0002},
	{`OP_SW,   5'd2,  5'd8,  16'h0010},
	{`OP_J,    5'd0,  5'd0,  16'h0002},
	{`OP_SW,   5'd3,  5'd8,  16'h0014},
	{`OP_SW,   5'd2,  5'd8,  16'h0018},
	// word 0x10 of data memory is preset, doubling it overflows
	{`OP_LW,   5'd11, 5'd0,  16'h0040},
	{`OP_ALU,  5'd12, 5'd11, 5'd11, 6'd0, `SUB_ADD},
	{`OP_SW,   5'd12, 5'd8,  16'h001c},
	{`OP_J,    5'd0,  5'd0,  16'h0000}
};

// expected stores in order, {byte address, data}
localparam int store_count = 12;
localparam logic [43:0] stores [store_count] = '{
	{12'h100, 32'hffff_fff1},
	{12'h104, 32'h0000_8001},
	{12'h108, 32'hffff_8001},
	{12'h10c, 32'hffff_fff0},
	{12'h110, 32'h0000_7ff1},
	{12'h114, 32'h0000_8001},
	{12'h118, 32'hffff_fff0},
	{12'h204, 32'hffff_8001},
	{12'h208, 32'h0000_0002},
	{12'h20c, 32'h0000_8001},
	{12'h218, 32'hffff_fff0},
	{12'h21c, 32'hfffe_0020}
};

`endif

// File: dv/tb_top.sv
`include "cpu_macros.svh"

module tb_top;
	timeunit 1ns;
	timeprecision 1ps;

	`include "tb_program.svh"

	localparam int timeout_cycles = 8 * prog_len + 20;
	// quiet cycles after the last store to catch a late extra one
	localparam int drain_cycles = 8;
	// lw words on the executed path
	localparam int load_count = 2;

	logic              clk;
	logic              rst;
	logic [`XLEN-1:0]  instruction;
	logic [`PC_W-1:0]  im_address;
	logic              dm_read;
	logic              dm_write;
	logic [`DM_AW-1:0] dm_address;
	logic [`XLEN-1:0]  dm_in;
	logic [`XLEN-1:0]  dm_out;
	logic              alu_overflow;

	logic [`XLEN-1:0] imem [1 << `PC_W];
	logic [`XLEN-1:0] dmem [1 << (`DM_AW - 2)];

	int cycle_count = 0;
	int overflow_count = 0;
	int read_count = 0;
	int store_idx = 0;
	int drain_count = 0;

	top u_dut (.*);

	always #50 clk = ~clk;

	// both memories answer in the same cycle
	assign instruction = imem[im_address];
	assign dm_out = dmem[dm_address[`DM_AW-1:2]];

	always @(posedge clk) begin
		if (!rst && dm_write) begin
			dmem[dm_address[`DM_AW-1:2]] <= dm_in;
		end
	end

	task automatic abort_run();
		$display("RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("[FAIL] %0d ns %s: got 0x%08h, expected 0x%08h",
				$time, name, actual, expected);
			abort_run();
		end
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		// opcode field stays zero so every fill word is a no-op
		for (int i = 0; i < (1 << `PC_W); i++) begin
			imem[i] = i;
		end
		for (int i = 0; i < (1 << (`DM_AW - 2)); i++) begin
			dmem[i] = 32'h7fff_0000 | i;
		end
		for (int i = 0; i < prog_len; i++) begin
			imem[i] = prog_words[i];
		end
		repeat (2) @(posedge clk);
		check_value("dm_write", 32'(dm_write), 32'd0);
		check_value("dm_read", 32'(dm_read), 32'd0);
		check_value("alu_overflow", 32'(alu_overflow), 32'd0);
		check_value("im_address", 32'(im_address), 32'd0);
		rst <= 1'b0;
		// first fetch after reset
		@(posedge clk);
		check_value("im_address", 32'(im_address), 32'd0);
	end

	always @(posedge clk) begin
		cycle_count++;
		if (!rst && alu_overflow) begin
			overflow_count++;
		end
		if (!rst && dm_read) begin
			read_count++;
		end
		if (!rst && dm_write) begin
			if (store_idx >= store_count) begin
				$display("unexpected store to 0x%03h after the last expected store",
					dm_address);
				abort_run();
			end else begin
				check_value("dm_address", 32'(dm_address),
					32'(stores[store_idx][43:32]));
				check_value("dm_in", dm_in, stores[store_idx][31:0]);
				store_idx++;
			end
		end
		if (store_idx == store_count) begin
			drain_count++;
			if (drain_count == drain_cycles) begin
				check_value("alu_overflow count", overflow_count, 32'd1);
				check_value("dm_read count", read_count, 32'(load_count));
				$display("RESULT: PASS");
				$finish;
			end
		end else if (cycle_count >= timeout_cycles) begin
			$display("timed out before all stores");
			abort_run();
		end
	end

endmodule

// File: hw/alu.sv
`include "cpu_macros.svh"

module alu (
	input  cpu_pkg::alu_op_e  alu_op,
	input  logic [`XLEN-1:0]  alu_src1,
	input  logic [`XLEN-1:0]  alu_src2,
	output logic [`XLEN-1:0]  alu_result,
	output logic              alu_zero,
	output logic              alu_overflow
);
	import cpu_pkg::*;

	logic [`XLEN-1:0] sum;
	logic [`XLEN-1:0] diff;
	logic             sign1;
	logic             sign2;

	assign sum = alu_src1 + alu_src2;
	assign diff = alu_src1 - alu_src2;
	assign sign1 = alu_src1[`XLEN-1];
	assign sign2 = alu_src2[`XLEN-1];

	always_comb begin
		alu_result = '0;
		alu_overflow = 1'b0;
		case (alu_op)
			ALU_ADD: begin
				alu_result = sum;
				// same-sign operands, result sign flipped
				alu_overflow = (sign1 == sign2) && (sum[`XLEN-1] != sign1);
			end
			ALU_SUB: begin
				alu_result = diff;
				alu_overflow = (sign1 != sign2) && (diff[`XLEN-1] != sign1);
			end
			ALU_AND: alu_result = alu_src1 & alu_src2;
			ALU_OR:  alu_result = alu_src1 | alu_src2;
			ALU_XOR: alu_result = alu_src1 ^ alu_src2;
			default: alu_result = '0;
		endcase
	end

	assign alu_zero = (alu_result == '0);

endmodule

// File: hw/controller.sv
`include "cpu_macros.svh"

module controller (
	input  cpu_pkg::instr_t    instruction,
	input  logic [`XLEN-1:0]   f_reg_rt_data,
	input  logic [`XLEN-1:0]   f_reg_ra_data,
	output logic [`REG_AW-1:0] reg_ra_addr,
	output logic [`REG_AW-1:0] reg_rb_addr,
	output logic [`REG_AW-1:0] reg_rt_addr,
	output logic [15:0]        imm16,
	output cpu_pkg::alu_op_e   alu_op,
	output cpu_pkg::src2_sel_e src2_sel,
	output cpu_pkg::imm_ext_e  imm_ext,
	output cpu_pkg::wb_sel_e   wb_sel,
	output logic               do_reg_write,
	output logic               do_dm_read,
	output logic               do_dm_write,
	output logic               is_branch_taken,
	output logic               is_jump
);
	import cpu_pkg::*;

	logic is_beq;
	logic reads_ra;
	logic reads_rb;

	// register fields from the r view, immediate from the i view
	assign reg_rt_addr = instruction.r_fmt.rt;
	assign reg_ra_addr = reads_ra ? instruction.r_fmt.ra : '0;
	assign reg_rb_addr = reads_rb ? instruction.r_fmt.rb : '0;
	assign imm16 = instruction.i_fmt.imm;

	always_comb begin
		alu_op = ALU_AND;
		src2_sel = SRC2_REG;
		imm_ext = EXT_SIGN;
		wb_sel = WB_ALU;
		do_reg_write = 1'b0;
		do_dm_read = 1'b0;
		do_dm_write = 1'b0;
		is_beq = 1'b0;
		is_jump = 1'b0;
		reads_ra = 1'b0;
		reads_rb = 1'b0;
		case (instruction.r_fmt.opcode)
			`OP_ALU: begin
				case (instruction.r_fmt.sub_op)
					`SUB_ADD, `SUB_SUB, `SUB_AND, `SUB_OR, `SUB_XOR: begin
						alu_op = alu_op_e'(instruction.r_fmt.sub_op);
						do_reg_write = 1'b1;
						reads_ra = 1'b1;
						reads_rb = 1'b1;
					end
					default: do_reg_write = 1'b0;
				endcase
			end
			`OP_ADDI: begin
				alu_op = ALU_ADD;
				src2_sel = SRC2_IMM;
				do_reg_write = 1'b1;
				reads_ra = 1'b1;
			end
			`OP_ORI: begin
				alu_op = ALU_OR;
				src2_sel = SRC2_IMM;
				imm_ext = EXT_ZERO;
				do_reg_write = 1'b1;
				reads_ra = 1'b1;
			end
			`OP_LW: begin
				alu_op = ALU_ADD;
				src2_sel = SRC2_IMM;
				wb_sel = WB_MEM;
				do_reg_write = 1'b1;
				do_dm_read = 1'b1;
				reads_ra = 1'b1;
			end
			`OP_SW: begin
				alu_op = ALU_ADD;
				src2_sel = SRC2_IMM;
				do_dm_write = 1'b1;
				reads_ra = 1'b1;
			end
			`OP_BEQ: begin
				is_beq = 1'b1;
				reads_ra = 1'b1;
			end
			`OP_J: is_jump = 1'b1;
			default: is_jump = 1'b0;
		endcase
	end

	// compare on bypassed operands, resolved in decode
	assign is_branch_taken = is_beq && (f_reg_rt_data == f_reg_ra_data);

endmodule

// File: hw/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// widths
`define XLEN   32
`define PC_W   10
`define DM_AW  12
`define REG_AW 5

// major opcodes, zero is left unused so a cleared word decodes as a no-op
`define OP_ALU  6'b100000
`define OP_ADDI 6'b101000
`define OP_ORI  6'b101100
`define OP_LW   6'b000010
`define OP_SW   6'b001010
`define OP_BEQ  6'b100110
`define OP_J    6'b100100

// alu sub-op field of the r format
`define SUB_ADD 5'b00000
`define SUB_SUB 5'b00001
`define SUB_AND 5'b00010
`define SUB_XOR 5'b00011
`define SUB_OR  5'b00100

`endif

// File: hw/cpu_pkg.sv
`include "cpu_macros.svh"

package cpu_pkg;

	typedef struct packed {
		logic [5:0]         opcode;
		logic [`REG_AW-1:0] rt;
		logic [`REG_AW-1:0] ra;
		logic [`REG_AW-1:0] rb;
		logic [5:0]         unused;
		logic [4:0]         sub_op;
	} r_fmt_t;

	typedef struct packed {
		logic [5:0]         opcode;
		logic [`REG_AW-1:0] rt;
		logic [`REG_AW-1:0] ra;
		logic [15:0]        imm;
	} i_fmt_t;

	// one fetched word, two views
	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
	} instr_t;

	typedef enum logic [4:0] {
		ALU_ADD = `SUB_ADD,
		ALU_SUB = `SUB_SUB,
		ALU_AND = `SUB_AND,
		ALU_XOR = `SUB_XOR,
		ALU_OR  = `SUB_OR
	} alu_op_e;

	typedef enum logic {SRC2_REG, SRC2_IMM} src2_sel_e;

	typedef enum logic {EXT_SIGN, EXT_ZERO} imm_ext_e;

	typedef enum logic {WB_ALU, WB_MEM} wb_sel_e;

endpackage

// File: hw/datapath_mux.sv
`include "cpu_macros.svh"

module datapath_mux (
	input  logic [15:0]        imm16,
	input  cpu_pkg::imm_ext_e  imm_ext,
	input  cpu_pkg::src2_sel_e src2_sel,
	input  logic [`XLEN-1:0]   f_reg_rb_data,
	input  cpu_pkg::wb_sel_e   mem_wb_sel,
	input  logic [`XLEN-1:0]   mem_alu_result,
	input  logic [`XLEN-1:0]   dm_out,
	output logic [`XLEN-1:0]   imm_extend,
	output logic [`XLEN-1:0]   alu_src2,
	output logic [`XLEN-1:0]   write_reg_data
);
	import cpu_pkg::*;

	logic [`XLEN-17:0] imm_upper;

	// ori takes zero extension, the rest sign
	assign imm_upper = (imm_ext == EXT_ZERO) ? '0 : {(`XLEN-16){imm16[15]}};
	assign imm_extend = {imm_upper, imm16};

	assign alu_src2 = (src2_sel == SRC2_IMM) ? imm_extend : f_reg_rb_data;

	// memory stage result, also the bypass source for decode
	assign write_reg_data = (mem_wb_sel == WB_MEM) ? dm_out : mem_alu_result;

endmodule

// File: hw/forward.sv
`include "cpu_macros.svh"

module forward (
	input  logic [`REG_AW-1:0] reg_ra_addr,
	input  logic [`REG_AW-1:0] reg_rb_addr,
	input  logic [`REG_AW-1:0] reg_rt_addr,
	input  logic [`XLEN-1:0]   reg_ra_data,
	input  logic [`XLEN-1:0]   reg_rb_data,
	input  logic [`XLEN-1:0]   reg_rt_data,
	input  logic [`REG_AW-1:0] ex_write_reg_addr,
	input  logic               ex_do_reg_write,
	input  logic               ex_do_dm_read,
	input  logic [`XLEN-1:0]   alu_result,
	input  logic [`REG_AW-1:0] mem_write_reg_addr,
	input  logic               mem_do_reg_write,
	input  logic [`XLEN-1:0]   write_reg_data,
	input  logic [`REG_AW-1:0] wb_write_reg_addr,
	input  logic               wb_do_reg_write,
	input  logic [`XLEN-1:0]   wb_write_reg_data,
	output logic [`XLEN-1:0]   f_reg_ra_data,
	output logic [`XLEN-1:0]   f_reg_rb_data,
	output logic [`XLEN-1:0]   f_reg_rt_data,
	output logic               do_hazard
);

	// newest in-flight value wins
	function automatic logic [`XLEN-1:0] bypass(
		input logic [`REG_AW-1:0] addr,
		input logic [`XLEN-1:0]   raw
	);
		if (addr == '0) begin
			return raw;
		end
		if (ex_do_reg_write && !ex_do_dm_read && ex_write_reg_addr == addr) begin
			return alu_result;
		end
		if (mem_do_reg_write && mem_write_reg_addr == addr) begin
			return write_reg_data;
		end
		if (wb_do_reg_write && wb_write_reg_addr == addr) begin
			return wb_write_reg_data;
		end
		return raw;
	endfunction

	// load data not ready until memory stage
	function automatic logic load_hit(input logic [`REG_AW-1:0] addr);
		return ex_do_dm_read && ex_do_reg_write && addr != '0 && ex_write_reg_addr == addr;
	endfunction

	always_comb begin
		f_reg_ra_data = bypass(reg_ra_addr, reg_ra_data);
		f_reg_rb_data = bypass(reg_rb_addr, reg_rb_data);
		f_reg_rt_data = bypass(reg_rt_addr, reg_rt_data);
		do_hazard = load_hit(reg_ra_addr) || load_hit(reg_rb_addr) || load_hit(reg_rt_addr);
	end

endmodule

// File: hw/pc.sv
`include "cpu_macros.svh"

module pc (
	input  logic             clk,
	input  logic             rst,
	input  logic [15:0]      imm16,
	input  logic             is_branch_taken,
	input  logic             is_jump,
	input  logic             do_hazard,
	output logic [`PC_W-1:0] current_pc,
	output logic             do_flush
);

	logic [`PC_W-1:0] decode_pc;
	logic [`XLEN-1:0] offset;
	logic [`PC_W-1:0] target_pc;

	assign offset = {{(`XLEN-16){imm16[15]}}, imm16};
	assign target_pc = decode_pc + offset[`PC_W-1:0];

	// a stalled branch sees stale operands, so it waits too
	assign do_flush = (is_branch_taken || is_jump) && !do_hazard;

	always_ff @(posedge clk) begin
		if (rst) begin
			current_pc <= '0;
			decode_pc <= '0;
		end else begin
			if (do_flush) begin
				current_pc <= target_pc;
			end else if (!do_hazard) begin
				current_pc <= current_pc + 1'b1;
			end
			// follows the fetch register
			if (!do_hazard) begin
				decode_pc <= current_pc;
			end
		end
	end

endmodule

// File: hw/regfile.sv
`include "cpu_macros.svh"

module regfile (
	input  logic               clk,
	input  logic               rst,
	input  logic [`REG_AW-1:0] reg_ra_addr,
	input  logic [`REG_AW-1:0] reg_rb_addr,
	input  logic [`REG_AW-1:0] reg_rt_addr,
	input  logic [`REG_AW-1:0] write_reg_addr,
	input  logic [`XLEN-1:0]   write_reg_data,
	input  logic               do_reg_write,
	output logic [`XLEN-1:0]   reg_ra_data,
	output logic [`XLEN-1:0]   reg_rb_data,
	output logic [`XLEN-1:0]   reg_rt_data
);

	logic [`XLEN-1:0] regs [1 << `REG_AW];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < (1 << `REG_AW); i++) begin
				regs[i] <= '0;
			end
		end else if (do_reg_write && write_reg_addr != '0) begin
			regs[write_reg_addr] <= write_reg_data;
		end
	end

	// r0 hardwired
	assign reg_ra_data = (reg_ra_addr == '0) ? '0 : regs[reg_ra_addr];
	assign reg_rb_data = (reg_rb_addr == '0) ? '0 : regs[reg_rb_addr];
	assign reg_rt_data = (reg_rt_addr == '0) ? '0 : regs[reg_rt_addr];

endmodule

// File: hw/regwalls.sv
`include "cpu_macros.svh"

module regwalls (
	input  logic               clk,
	input  logic               rst,
	input  logic               do_hazard,
	input  logic               do_flush,
	input  logic [`XLEN-1:0]   instruction,
	output cpu_pkg::instr_t    id_instruction,
	input  logic [`XLEN-1:0]   f_reg_ra_data,
	input  logic [`XLEN-1:0]   f_reg_rt_data,
	input  logic [`XLEN-1:0]   alu_src2,
	input  cpu_pkg::alu_op_e   alu_op,
	input  cpu_pkg::wb_sel_e   wb_sel,
	input  logic [`REG_AW-1:0] write_reg_addr,
	input  logic               do_reg_write,
	input  logic               do_dm_read,
	input  logic               do_dm_write,
	output logic [`XLEN-1:0]   ex_ra_data,
	output logic [`XLEN-1:0]   ex_alu_src2,
	output cpu_pkg::alu_op_e   ex_alu_op,
	output logic [`REG_AW-1:0] ex_write_reg_addr,
	output logic               ex_do_reg_write,
	output logic               ex_do_dm_read,
	input  logic [`XLEN-1:0]   alu_result,
	output logic [`XLEN-1:0]   mem_alu_result,
	output logic [`XLEN-1:0]   mem_rt_data,
	output cpu_pkg::wb_sel_e   mem_wb_sel,
	output logic [`REG_AW-1:0] mem_write_reg_addr,
	output logic               mem_do_reg_write,
	output logic               mem_do_dm_read,
	output logic               mem_do_dm_write,
	input  logic [`XLEN-1:0]   write_reg_data,
	output logic [`REG_AW-1:0] wb_write_reg_addr,
	output logic [`XLEN-1:0]   wb_write_reg_data,
	output logic               wb_do_reg_write
);
	import cpu_pkg::*;

	logic [`XLEN-1:0] ex_rt_data;
	wb_sel_e          ex_wb_sel;
	logic             ex_do_dm_write;

	// fetch/decode, zero word is a no-op
	always_ff @(posedge clk) begin
		if (rst || do_flush) begin
			id_instruction <= '0;
		end else if (!do_hazard) begin
			id_instruction <= instruction;
		end
	end

	// decode/execute
	always_ff @(posedge clk) begin
		ex_ra_data <= f_reg_ra_data;
		ex_rt_data <= f_reg_rt_data;
		ex_alu_src2 <= alu_src2;
		ex_wb_sel <= wb_sel;
		ex_write_reg_addr <= write_reg_addr;
		if (rst || do_hazard) begin
			// bubble, and never an overflowing op
			ex_alu_op <= ALU_AND;
			ex_do_reg_write <= 1'b0;
			ex_do_dm_read <= 1'b0;
			ex_do_dm_write <= 1'b0;
		end else begin
			ex_alu_op <= alu_op;
			ex_do_reg_write <= do_reg_write;
			ex_do_dm_read <= do_dm_read;
			ex_do_dm_write <= do_dm_write;
		end
	end

	// execute/memory
	always_ff @(posedge clk) begin
		mem_alu_result <= alu_result;
		mem_rt_data <= ex_rt_data;
		mem_wb_sel <= ex_wb_sel;
		mem_write_reg_addr <= ex_write_reg_addr;
		if (rst) begin
			mem_do_reg_write <= 1'b0;
			mem_do_dm_read <= 1'b0;
			mem_do_dm_write <= 1'b0;
		end else begin
			mem_do_reg_write <= ex_do_reg_write;
			mem_do_dm_read <= ex_do_dm_read;
			mem_do_dm_write <= ex_do_dm_write;
		end
	end

	// memory/writeback
	always_ff @(posedge clk) begin
		wb_write_reg_addr <= mem_write_reg_addr;
		wb_write_reg_data <= write_reg_data;
		if (rst) begin
			wb_do_reg_write <= 1'b0;
		end else begin
			wb_do_reg_write <= mem_do_reg_write;
		end
	end

endmodule

// File: hw/top.sv
`include "cpu_macros.svh"

module top (
	input  logic              clk,
	input  logic              rst,
	input  logic [`XLEN-1:0]  instruction,
	output logic [`PC_W-1:0]  im_address,
	output logic              dm_read,
	output logic              dm_write,
	output logic [`DM_AW-1:0] dm_address,
	output logic [`XLEN-1:0]  dm_in,
	input  logic [`XLEN-1:0]  dm_out,
	output logic              alu_overflow
);
	import cpu_pkg::*;

	// decode
	instr_t             id_instruction;
	logic [`REG_AW-1:0] reg_ra_addr;
	logic [`REG_AW-1:0] reg_rb_addr;
	logic [`REG_AW-1:0] reg_rt_addr;
	logic [15:0]        imm16;
	alu_op_e            alu_op;
	src2_sel_e          src2_sel;
	imm_ext_e           imm_ext;
	wb_sel_e            wb_sel;
	logic               do_reg_write;
	logic               do_dm_read;
	logic               do_dm_write;
	logic               is_branch_taken;
	logic               is_jump;
	logic [`XLEN-1:0]   reg_ra_data;
	logic [`XLEN-1:0]   reg_rb_data;
	logic [`XLEN-1:0]   reg_rt_data;
	logic [`XLEN-1:0]   f_reg_ra_data;
	logic [`XLEN-1:0]   f_reg_rb_data;
	logic [`XLEN-1:0]   f_reg_rt_data;
	logic [`XLEN-1:0]   alu_src2;
	logic               do_hazard;
	logic               do_flush;

	// execute
	logic [`XLEN-1:0]   ex_ra_data;
	logic [`XLEN-1:0]   ex_alu_src2;
	alu_op_e            ex_alu_op;
	logic [`REG_AW-1:0] ex_write_reg_addr;
	logic               ex_do_reg_write;
	logic               ex_do_dm_read;
	logic [`XLEN-1:0]   alu_result;

	// memory
	logic [`XLEN-1:0]   mem_alu_result;
	wb_sel_e            mem_wb_sel;
	logic [`REG_AW-1:0] mem_write_reg_addr;
	logic               mem_do_reg_write;
	logic [`XLEN-1:0]   write_reg_data;

	// writeback
	logic [`REG_AW-1:0] wb_write_reg_addr;
	logic [`XLEN-1:0]   wb_write_reg_data;
	logic               wb_do_reg_write;

	assign dm_address = mem_alu_result[`DM_AW-1:0];

	controller u_controller (.instruction(id_instruction), .*);

	regfile u_regfile (
		.write_reg_addr(wb_write_reg_addr),
		.write_reg_data(wb_write_reg_data),
		.do_reg_write(wb_do_reg_write),
		.*
	);

	forward u_forward (.*);

	pc u_pc (.current_pc(im_address), .*);

	datapath_mux u_datapath_mux (.imm_extend(), .*);

	alu u_alu (
		.alu_op(ex_alu_op),
		.alu_src1(ex_ra_data),
		.alu_src2(ex_alu_src2),
		.alu_zero(),
		.*
	);

	regwalls u_regwalls (
		.write_reg_addr(reg_rt_addr),
		.mem_rt_data(dm_in),
		.mem_do_dm_read(dm_read),
		.mem_do_dm_write(dm_write),
		.*
	);

endmodule

// File: sim.f
+incdir+hw
+incdir+dv
hw/cpu_pkg.sv
hw/alu.sv
hw/regfile.sv
hw/controller.sv
hw/pc.sv
hw/forward.sv
hw/datapath_mux.sv
hw/regwalls.sv
hw/top.sv
dv/tb_top.sv
